// File: src/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data, instruction and address widths of the core.
`define XLEN 32
`define ILEN 32
`define ALEN 32

// the first instruction is fetched from this address.
`define PC_RESET 32'h0000_0000

`endif

// File: src/rv_pkg.sv
package rv_pkg;

    // register view of the instruction word.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // immediate view, the same bits with funct7 and rs2 merged into imm12.
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b,
        alu_br_eq,
        alu_br_ne,
        alu_jal
    } alu_op_e;

    typedef enum logic [1:0] {
        trap_none,
        trap_illegal_instr
    } trap_cause_e;

endpackage

// File: src/stage_if.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

// out_stalled means the producer has nothing valid to offer.
// in_stalled means the consumer cannot take it this cycle.
interface decode_exec_if;
    import rv_pkg::*;

    logic             out_stalled;
    logic             in_stalled;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] imm;
    logic [4:0]       rd;
    logic             reg_write;
    logic [`ALEN-1:0] pc;
    logic [`ALEN-1:0] next_pc;
    trap_cause_e      trap_cause;

    modport producer (output out_stalled, alu_op, operand_a, operand_b, imm, rd, reg_write,
                      pc, next_pc, trap_cause, input in_stalled);
    modport consumer (input out_stalled, alu_op, operand_a, operand_b, imm, rd, reg_write,
                      pc, next_pc, trap_cause, output in_stalled);
endinterface

interface exec_wb_if;
    import rv_pkg::*;

    logic             out_stalled;
    logic             in_stalled;
    logic [4:0]       rd;
    logic             reg_write;
    logic [`XLEN-1:0] result;
    logic [`ALEN-1:0] pc;
    trap_cause_e      trap_cause;

    modport producer (output out_stalled, rd, reg_write, result, pc, trap_cause,
                      input in_stalled);
    modport consumer (input out_stalled, rd, reg_write, result, pc, trap_cause,
                      output in_stalled);
endinterface

// File: src/ifetch.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module ifetch (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic [`ALEN-1:0] redirect_pc,
    output logic             imem_req,
    output logic [`ALEN-1:0] imem_addr,
    input  logic             imem_valid,
    input  logic [`ILEN-1:0] imem_rdata,
    output rv_pkg::instr_u   instr,
    output logic [`ALEN-1:0] instr_pc,
    output logic             out_stalled,
    input  logic             in_stalled
);
    logic [`ALEN-1:0] pc;
    logic             drop;
    logic             out_valid;
    logic             resp;
    logic             take;
    logic             issue;

    assign resp        = imem_req && imem_valid;
    assign take        = out_valid && !in_stalled;
    assign out_stalled = !out_valid;

    // a request goes out only when its answer is sure to find the output register empty.
    assign issue = !imem_req && !flush && (!out_valid || take);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= `PC_RESET;
            imem_req  <= 1'b0;
            imem_addr <= `PC_RESET;
            drop      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (resp) begin
                imem_req <= 1'b0;
                drop     <= 1'b0;
            end else if (issue) begin
                imem_req  <= 1'b1;
                imem_addr <= pc;
            end
            if (flush) begin
                pc        <= redirect_pc;
                out_valid <= 1'b0;
                // the answer to the old address is still on its way and must be thrown away.
                if (imem_req && !imem_valid)
                    drop <= 1'b1;
            end else if (resp && !drop) begin
                pc        <= pc + 4;
                out_valid <= 1'b1;
            end else if (take) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp && !drop && !flush) begin
            instr    <= imem_rdata;
            instr_pc <= imem_addr;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && !imem_valid |=> imem_req && $stable(imem_addr))
        else $error("imem_addr changed while a request was waiting");

endmodule

// File: src/decode.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module decode (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  rv_pkg::instr_u   instr,
    input  logic [`ALEN-1:0] instr_pc,
    input  logic             instr_out_stalled,
    output logic             instr_in_stalled,
    output logic [4:0]       rs1_sel,
    input  logic [`XLEN-1:0] rs1_data,
    output logic [4:0]       rs2_sel,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [4:0]       fwd_exec_rd,
    input  logic [`XLEN-1:0] fwd_exec_data,
    input  logic [4:0]       fwd_wb_rd,
    input  logic [`XLEN-1:0] fwd_wb_data,
    decode_exec_if.producer  dex
);
    import rv_pkg::*;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    logic [`ILEN-1:0] raw;
    alu_op_e          d_op;
    logic [`XLEN-1:0] d_imm;
    logic [4:0]       d_rs1;
    logic [4:0]       d_rs2;
    logic             d_use_imm;
    logic             d_we;
    trap_cause_e      d_trap;
    logic             valid_q;
    logic             use_imm_q;
    logic             accept;
    logic             take;

    // exec holds the youngest result, so it wins over writeback.
    function automatic logic [`XLEN-1:0] bypass(input logic [4:0] sel,
                                                input logic [`XLEN-1:0] rf_data);
        logic [`XLEN-1:0] value;
        value = rf_data;
        if (sel != 5'd0 && sel == fwd_wb_rd)
            value = fwd_wb_data;
        if (sel != 5'd0 && sel == fwd_exec_rd)
            value = fwd_exec_data;
        return value;
    endfunction

    assign raw              = instr;
    assign take             = valid_q && !dex.in_stalled;
    assign instr_in_stalled = valid_q && dex.in_stalled;
    assign accept           = !instr_out_stalled && !instr_in_stalled && !flush;
    assign dex.out_stalled  = !valid_q;
    assign dex.next_pc      = dex.pc + 4;

    always_comb begin
        d_op      = alu_add;
        d_imm     = '0;
        d_rs1     = instr.r.rs1;
        d_rs2     = instr.r.rs2;
        d_use_imm = 1'b0;
        d_we      = 1'b1;
        d_trap    = trap_none;
        case (instr.r.opcode)
            OP_REG: begin
                case ({instr.r.funct7, instr.r.funct3})
                    10'b0000000_000: d_op = alu_add;
                    10'b0100000_000: d_op = alu_sub;
                    10'b0000000_111: d_op = alu_and;
                    10'b0000000_110: d_op = alu_or;
                    10'b0000000_100: d_op = alu_xor;
                    10'b0000000_010: d_op = alu_slt;
                    default:         d_trap = trap_illegal_instr;
                endcase
            end
            OP_IMM: begin
                // ADDI is the only member of the immediate group.
                d_rs1     = instr.i.rs1;
                d_imm     = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
                d_use_imm = 1'b1;
                if (instr.i.funct3 != 3'b000)
                    d_trap = trap_illegal_instr;
            end
            OP_LUI: begin
                // rs1 is forced to x0 so that operand a reads as zero.
                d_op      = alu_pass_b;
                d_rs1     = 5'd0;
                d_imm     = {raw[31:12], 12'b0};
                d_use_imm = 1'b1;
            end
            OP_JAL: begin
                d_op  = alu_jal;
                d_imm = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
            end
            OP_BRANCH: begin
                d_we  = 1'b0;
                d_imm = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
                case (instr.r.funct3)
                    3'b000:  d_op = alu_br_eq;
                    3'b001:  d_op = alu_br_ne;
                    default: d_trap = trap_illegal_instr;
                endcase
            end
            default: d_trap = trap_illegal_instr;
        endcase
        if (d_trap != trap_none)
            d_we = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (flush)
            valid_q <= 1'b0;
        else if (accept)
            valid_q <= 1'b1;
        else if (take)
            valid_q <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dex.alu_op     <= d_op;
            dex.imm        <= d_imm;
            dex.rd         <= d_we ? instr.r.rd : 5'd0;
            dex.reg_write  <= d_we;
            dex.pc         <= instr_pc;
            dex.trap_cause <= d_trap;
            rs1_sel        <= d_rs1;
            rs2_sel        <= d_rs2;
            use_imm_q      <= d_use_imm;
        end
    end

    // operands are resolved while the instruction waits for exec, so no hazard stalls it.
    always_comb begin
        dex.operand_a = bypass(rs1_sel, rs1_data);
        dex.operand_b = use_imm_q ? dex.imm : bypass(rs2_sel, rs2_data);
    end

endmodule

// File: src/exec.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module exec (
    input  logic             clk,
    input  logic             rst_n,
    decode_exec_if.consumer  dex,
    exec_wb_if.producer      ewb,
    output logic             flush,
    output logic [`ALEN-1:0] redirect_pc,
    output logic [4:0]       fwd_rd,
    output logic [`XLEN-1:0] fwd_data
);
    import rv_pkg::*;

    logic             valid_q;
    logic             accept;
    logic             take;
    logic             taken;
    logic [`XLEN-1:0] alu_result;

    assign take           = valid_q && !ewb.in_stalled;
    assign dex.in_stalled = valid_q && ewb.in_stalled;
    assign accept         = !dex.out_stalled && !dex.in_stalled;
    assign ewb.out_stalled = !valid_q;

    always_comb begin
        alu_result = '0;
        taken      = 1'b0;
        case (dex.alu_op)
            alu_add:    alu_result = dex.operand_a + dex.operand_b;
            alu_sub:    alu_result = dex.operand_a - dex.operand_b;
            alu_and:    alu_result = dex.operand_a & dex.operand_b;
            alu_or:     alu_result = dex.operand_a | dex.operand_b;
            alu_xor:    alu_result = dex.operand_a ^ dex.operand_b;
            alu_slt:    alu_result = {{(`XLEN-1){1'b0}},
                                      $signed(dex.operand_a) < $signed(dex.operand_b)};
            alu_pass_b: alu_result = dex.operand_b;
            alu_br_eq:  taken = dex.operand_a == dex.operand_b;
            alu_br_ne:  taken = dex.operand_a != dex.operand_b;
            alu_jal: begin
                // the link value is the address after the jump.
                alu_result = dex.next_pc;
                taken      = 1'b1;
            end
            default: ;
        endcase
    end

    // the redirect is raised in the same cycle that the branch is accepted.
    assign flush       = accept && taken && dex.trap_cause == trap_none;
    assign redirect_pc = dex.pc + dex.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (accept)
            valid_q <= 1'b1;
        else if (take)
            valid_q <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ewb.rd         <= dex.rd;
            ewb.reg_write  <= dex.reg_write;
            ewb.result     <= alu_result;
            ewb.pc         <= dex.pc;
            ewb.trap_cause <= dex.trap_cause;
        end
    end

    assign fwd_rd   = (valid_q && ewb.reg_write) ? ewb.rd : 5'd0;
    assign fwd_data = ewb.result;

    // the redirecting instruction is legal, and decode has dropped the wrong-path entry.
    a_flush_clean: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !ewb.out_stalled && ewb.trap_cause == trap_none && dex.out_stalled)
        else $error("flush came with a trap or left a wrong-path entry in decode");

endmodule

// File: src/writeback.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module writeback (
    input  logic                clk,
    input  logic                rst_n,
    exec_wb_if.consumer         ewb,
    output logic                rf_we,
    output logic [4:0]          rf_waddr,
    output logic [`XLEN-1:0]    rf_wdata,
    output logic                retire_valid,
    output logic [`ALEN-1:0]    retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`XLEN-1:0]    retire_data,
    output logic                halted,
    output rv_pkg::trap_cause_e trap_cause
);
    import rv_pkg::*;

    logic accept;
    logic reg_write_q;

    // a trap in the retire slot blocks the next instruction before halted is even set.
    assign ewb.in_stalled = halted || (retire_valid && trap_cause != trap_none);
    assign accept         = !ewb.out_stalled && !ewb.in_stalled;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
            trap_cause   <= trap_none;
        end else begin
            retire_valid <= accept;
            if (accept)
                trap_cause <= ewb.trap_cause;
            if (retire_valid && trap_cause != trap_none)
                halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            retire_pc   <= ewb.pc;
            retire_rd   <= ewb.rd;
            retire_data <= ewb.result;
            reg_write_q <= ewb.reg_write;
        end
    end

    // the write address reads as x0 when nothing is written, which keeps forwarding quiet.
    assign rf_we    = retire_valid && reg_write_q;
    assign rf_waddr = rf_we ? retire_rd : 5'd0;
    assign rf_wdata = retire_data;

endmodule

// File: src/int_regfile.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module int_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             we,
    input  logic [4:0]       waddr,
    input  logic [`XLEN-1:0] wdata,
    input  logic [4:0]       rs1_sel,
    output logic [`XLEN-1:0] rs1_data,
    input  logic [4:0]       rs2_sel,
    output logic [`XLEN-1:0] rs2_data,
    input  logic [4:0]       dbg_sel,
    output logic [`XLEN-1:0] dbg_data
);
    // x0 has no storage.
    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs1_data = (rs1_sel == 5'd0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == 5'd0) ? '0 : regs[rs2_sel];
    assign dbg_data = (dbg_sel == 5'd0) ? '0 : regs[dbg_sel];

endmodule

// File: src/core.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module core (
    input  logic                clk,
    input  logic                rst_n,
    output logic                imem_req,
    output logic [`ALEN-1:0]    imem_addr,
    input  logic                imem_valid,
    input  logic [`ILEN-1:0]    imem_rdata,
    output logic                retire_valid,
    output logic [`ALEN-1:0]    retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`XLEN-1:0]    retire_data,
    output logic                halted,
    output rv_pkg::trap_cause_e trap_cause,
    input  logic [4:0]          reg_read_sel,
    output logic [`XLEN-1:0]    reg_read_data
);
    import rv_pkg::*;

    instr_u           fetch_instr;
    logic [`ALEN-1:0] fetch_pc;
    logic             fetch_out_stalled;
    logic             decode_in_stalled;
    logic             flush;
    logic [`ALEN-1:0] redirect_pc;
    logic [4:0]       rs1_sel;
    logic [`XLEN-1:0] rs1_data;
    logic [4:0]       rs2_sel;
    logic [`XLEN-1:0] rs2_data;
    logic [4:0]       exec_fwd_rd;
    logic [`XLEN-1:0] exec_fwd_data;
    logic             rf_we;
    logic [4:0]       rf_waddr;
    logic [`XLEN-1:0] rf_wdata;

    decode_exec_if dex ();
    exec_wb_if     ewb ();

    ifetch u_ifetch (
        .clk, .rst_n, .flush, .redirect_pc,
        .imem_req, .imem_addr, .imem_valid, .imem_rdata,
        .instr       (fetch_instr),
        .instr_pc    (fetch_pc),
        .out_stalled (fetch_out_stalled),
        .in_stalled  (decode_in_stalled)
    );

    decode u_decode (
        .clk, .rst_n, .flush,
        .instr             (fetch_instr),
        .instr_pc          (fetch_pc),
        .instr_out_stalled (fetch_out_stalled),
        .instr_in_stalled  (decode_in_stalled),
        .rs1_sel, .rs1_data, .rs2_sel, .rs2_data,
        .fwd_exec_rd       (exec_fwd_rd),
        .fwd_exec_data     (exec_fwd_data),
        .fwd_wb_rd         (rf_waddr),
        .fwd_wb_data       (rf_wdata),
        .dex               (dex.producer)
    );

    exec u_exec (
        .clk, .rst_n,
        .dex         (dex.consumer),
        .ewb         (ewb.producer),
        .flush, .redirect_pc,
        .fwd_rd      (exec_fwd_rd),
        .fwd_data    (exec_fwd_data)
    );

    writeback u_writeback (
        .clk, .rst_n,
        .ewb (ewb.consumer),
        .rf_we, .rf_waddr, .rf_wdata,
        .retire_valid, .retire_pc, .retire_rd, .retire_data,
        .halted, .trap_cause
    );

    int_regfile u_regfile (
        .clk, .rst_n,
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata),
        .rs1_sel, .rs1_data, .rs2_sel, .rs2_data,
        .dbg_sel  (reg_read_sel),
        .dbg_data (reg_read_data)
    );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);
    // half of the 20 ns period.
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// File: verif/core_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module core_tb;
    import rv_pkg::*;

    localparam int ROM_WORDS   = 64;
    localparam int EXP_RETIRES = 36;
    // reset, the retires themselves, the quiet cycles after the halt and the register scan.
    localparam int CYCLE_LIMIT = 16 + 40 * EXP_RETIRES + 8 + 2 * 32;

    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct7 and funct3 of the register operations, side by side.
    localparam logic [9:0] ADD_F = {7'h00, 3'b000};
    localparam logic [9:0] SUB_F = {7'h20, 3'b000};
    localparam logic [9:0] AND_F = {7'h00, 3'b111};
    localparam logic [9:0] OR_F  = {7'h00, 3'b110};
    localparam logic [9:0] XOR_F = {7'h00, 3'b100};
    localparam logic [9:0] SLT_F = {7'h00, 3'b010};
    localparam logic [9:0] MUL_F = {7'h01, 3'b000};
    localparam logic [2:0] BEQ_F3 = 3'b000;
    localparam logic [2:0] BNE_F3 = 3'b001;

    logic             clk;
    logic             rst_n;
    logic             imem_req;
    logic [`ALEN-1:0] imem_addr;
    logic             imem_valid;
    logic [`ILEN-1:0] imem_rdata;
    logic             retire_valid;
    logic [`ALEN-1:0] retire_pc;
    logic [4:0]       retire_rd;
    logic [`XLEN-1:0] retire_data;
    logic             halted;
    trap_cause_e      trap_cause;
    logic [4:0]       reg_read_sel;
    logic [`XLEN-1:0] reg_read_data;

    logic [`ILEN-1:0] rom [0:ROM_WORDS-1];
    logic [`XLEN-1:0] shadow_regs [0:31];
    logic [`ALEN-1:0] shadow_pc;
    logic             trap_seen;
    int               retired;
    int               cycles;
    integer           seed;
    int               wait_cnt;
    logic             pending;

    tb_clk_gen u_clk_gen (.clk);

    core DUT (
        .clk, .rst_n,
        .imem_req, .imem_addr, .imem_valid, .imem_rdata,
        .retire_valid, .retire_pc, .retire_rd, .retire_data,
        .halted, .trap_cause,
        .reg_read_sel, .reg_read_data
    );

    task automatic stop_failed();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
        stop_failed();
    endtask

    task automatic plain_error(input string msg);
        $display("error: %s", msg);
        stop_failed();
    endtask

    function automatic logic [31:0] rtype(input logic [9:0] f, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {f[9:3], rs2, rs1, f[2:0], rd, OPC_REG};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // unused words carry an illegal opcode and mix every address bit into the rest.
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:7] ^ addr[24:0], 7'h7f};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:8] == 24'd0)
            return rom[addr[7:2]];
        return fill_word(addr);
    endfunction

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = fill_word(32'(i) << 2);
        // a dependent chain that leans on both forwarding paths.
        rom[0]  = addi(5'd1, 5'd0, 12'd5);
        rom[1]  = addi(5'd2, 5'd1, 12'd3);
        rom[2]  = rtype(ADD_F, 5'd3, 5'd1, 5'd2);
        rom[3]  = rtype(SUB_F, 5'd4, 5'd3, 5'd1);
        rom[4]  = rtype(AND_F, 5'd5, 5'd4, 5'd2);
        rom[5]  = rtype(OR_F, 5'd6, 5'd5, 5'd1);
        rom[6]  = rtype(XOR_F, 5'd7, 5'd6, 5'd3);
        rom[7]  = rtype(SLT_F, 5'd8, 5'd7, 5'd1);
        rom[8]  = rtype(SLT_F, 5'd9, 5'd1, 5'd7);
        rom[9]  = lui(5'd10, 20'habcde);
        rom[10] = addi(5'd11, 5'd0, 12'hfff);
        rom[11] = rtype(SLT_F, 5'd12, 5'd11, 5'd1);
        // the write to x0 must vanish before the next read of x0.
        rom[12] = addi(5'd0, 5'd1, 12'd7);
        rom[13] = rtype(ADD_F, 5'd13, 5'd0, 5'd1);
        rom[14] = branch(BEQ_F3, 5'd2, 5'd4, 13'd8);
        rom[15] = addi(5'd14, 5'd0, 12'd99);
        rom[16] = branch(BNE_F3, 5'd1, 5'd13, 13'd8);
        rom[17] = branch(BNE_F3, 5'd1, 5'd2, 13'd8);
        rom[18] = addi(5'd14, 5'd0, 12'd77);
        rom[19] = branch(BEQ_F3, 5'd1, 5'd2, 13'd8);
        rom[20] = jal(5'd15, 21'd12);
        rom[21] = addi(5'd14, 5'd0, 12'd55);
        rom[22] = addi(5'd14, 5'd0, 12'd66);
        rom[23] = rtype(ADD_F, 5'd16, 5'd15, 5'd10);
        rom[24] = rtype(XOR_F, 5'd17, 5'd16, 5'd11);
        rom[25] = addi(5'd18, 5'd17, 12'h800);
        rom[26] = jal(5'd0, 21'd8);
        rom[27] = addi(5'd19, 5'd0, 12'd1);
        rom[28] = addi(5'd20, 5'd18, 12'd1);
        // a backward loop of five turns, x1 holds the bound.
        rom[29] = addi(5'd21, 5'd21, 12'd1);
        rom[30] = branch(BNE_F3, 5'd21, 5'd1, 13'h1ffc);
        rom[31] = branch(BNE_F3, 5'd20, 5'd0, 13'd8);
        rom[32] = addi(5'd22, 5'd0, 12'd1);
        rom[33] = rtype(MUL_F, 5'd23, 5'd1, 5'd2);
    endtask

    // the instruction set model, one call per retired instruction.
    task automatic predict(input logic [31:0] w, input logic [31:0] pc,
                           output logic [4:0] rd, output logic [31:0] data,
                           output logic bad, output logic [31:0] npc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        a     = shadow_regs[w[19:15]];
        b     = shadow_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        rd    = w[11:7];
        data  = '0;
        bad   = 1'b0;
        npc   = pc + 4;
        case (w[6:0])
            OPC_REG: begin
                case ({w[31:25], w[14:12]})
                    ADD_F:   data = a + b;
                    SUB_F:   data = a - b;
                    AND_F:   data = a & b;
                    OR_F:    data = a | b;
                    XOR_F:   data = a ^ b;
                    SLT_F:   data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: bad = 1'b1;
                endcase
            end
            OPC_IMM: begin
                if (w[14:12] == 3'b000)
                    data = a + imm_i;
                else
                    bad = 1'b1;
            end
            OPC_LUI: data = {w[31:12], 12'b0};
            OPC_JAL: begin
                data = pc + 4;
                npc  = pc + imm_j;
            end
            OPC_BRANCH: begin
                rd = 5'd0;
                if (w[14:12] == BEQ_F3 && a == b)
                    npc = pc + imm_b;
                else if (w[14:12] == BNE_F3 && a != b)
                    npc = pc + imm_b;
                else if (w[14:12] != BEQ_F3 && w[14:12] != BNE_F3)
                    bad = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            rd  = 5'd0;
            npc = pc;
        end
    endtask

    task automatic scan_registers();
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            reg_read_sel = 5'(i);
            @(negedge clk);
            assert (reg_read_data == shadow_regs[i])
                else value_mismatch($sformatf("reg_read_data[x%0d]", i), reg_read_data,
                                    shadow_regs[i]);
        end
    endtask

    // instruction memory that answers each request after 1 to 3 cycles.
    initial begin
        seed       = 23;
        imem_valid = 1'b0;
        imem_rdata = '0;
        pending    = 1'b0;
        wait_cnt   = 0;
        forever begin
            @(negedge clk);
            imem_valid = 1'b0;
            if (!rst_n) begin
                pending = 1'b0;
            end else begin
                if (imem_req && !pending) begin
                    pending  = 1'b1;
                    wait_cnt = $unsigned($random(seed)) % 3;
                end
                if (pending) begin
                    if (wait_cnt == 0) begin
                        imem_valid = 1'b1;
                        imem_rdata = fetch_word(imem_addr);
                        pending    = 1'b0;
                    end else begin
                        wait_cnt = wait_cnt - 1;
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic        exp_bad;
        logic [31:0] next_pc;
        trap_cause_e exp_cause;
        if (!rst_n) begin
            assert (!imem_req && !retire_valid && !halted)
                else plain_error("imem_req, retire_valid or halted is high during reset");
            shadow_pc = `PC_RESET;
            for (int i = 0; i < 32; i++)
                shadow_regs[i] = '0;
            trap_seen = 1'b0;
            retired   = 0;
        end else begin
            assert (halted == trap_seen)
                else plain_error("halted does not follow the retire of the illegal word");
            if (retire_valid) begin
                assert (!trap_seen) else plain_error("an instruction retired after the halt");
                assert (retire_pc == shadow_pc)
                    else value_mismatch("retire_pc", retire_pc, shadow_pc);
                predict(fetch_word(shadow_pc), shadow_pc, exp_rd, exp_data, exp_bad, next_pc);
                exp_cause = exp_bad ? trap_illegal_instr : trap_none;
                assert (retire_rd == exp_rd)
                    else value_mismatch("retire_rd", 32'(retire_rd), 32'(exp_rd));
                if (exp_rd != 5'd0) begin
                    assert (retire_data == exp_data)
                        else value_mismatch("retire_data", retire_data, exp_data);
                    shadow_regs[exp_rd] = exp_data;
                end
                assert (trap_cause == exp_cause)
                    else value_mismatch("trap_cause", 32'(trap_cause), 32'(exp_cause));
                shadow_pc = next_pc;
                retired   = retired + 1;
                if (exp_bad)
                    trap_seen = 1'b1;
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > CYCLE_LIMIT)
                plain_error("the run passed its cycle limit before the core halted");
        end
    end

    initial begin
        rst_n        = 1'b0;
        reg_read_sel = 5'd0;
        load_program();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        while (!halted)
            @(negedge clk);
        // nothing may retire while the core sits halted.
        repeat (8) @(negedge clk);
        scan_registers();
        if (retired == EXP_RETIRES && trap_seen) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            value_mismatch("retired count", retired, EXP_RETIRES);
        end
    end

endmodule

// File: core.f
+incdir+src
src/rv_pkg.sv
src/stage_if.sv
src/ifetch.sv
src/decode.sv
src/exec.sv
src/writeback.sv
src/int_regfile.sv
src/core.sv
verif/tb_clk_gen.sv
verif/core_tb.sv

// File: run.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f core.f --top-module core_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vcore_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
    exit 0
fi
exit 1
